/* source/functional_unit.sv */
/*
 * One 64-bit vector lane: adder, multiplier, logic ops and VID,
 * result selected by the captured operation
 */
`timescale 1ns/1ps

module functional_unit
    import vec_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    vec_op_if.lane     op_bus,      // Captured instruction
    output lane_word_u vd_o,        // Lane result
    output logic       sat_o        // Saturation in this lane
);

    lane_word_u vs1;
    lane_word_u vs2;
    lane_word_u old_vd;
    lane_word_u add_a;
    lane_word_u add_b;
    lane_word_u add_res;
    lane_word_u mul_res;
    lane_word_u mul_res_q;          // Second stage for MACC
    lane_word_u vid;

    // This lane's slice of the source vectors
    assign vs1    = op_bus.vs1[LANE_ID*LANE_W +: LANE_W];
    assign vs2    = op_bus.vs2[LANE_ID*LANE_W +: LANE_W];
    assign old_vd = op_bus.old_vd[LANE_ID*LANE_W +: LANE_W];

    // Breaks the multiply-to-add path for MACC
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mul_res_q <= '0;
        end else begin
            mul_res_q <= mul_res;
        end
    end

    assign add_a = (op_bus.op == OP_MACC) ? mul_res_q : vs2;    // vs2 - vs1 otherwise
    assign add_b = (op_bus.op == OP_MACC) ? old_vd    : vs1;

    vec_addsub u_addsub (
        .op_i  (op_bus.op),
        .sew_i (op_bus.sew),
        .a_i   (add_a),
        .b_i   (add_b),
        .sum_o (add_res),
        .sat_o (sat_o)
    );

    vec_mul u_mul (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .sew_i  (op_bus.sew),
        .a_i    (vs1),
        .b_i    (vs2),
        .prod_o (mul_res)
    );

    // Global element index, continuing from lower lanes
    always_comb begin
        vid = '0;
        case (op_bus.sew)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    vid.b[i] = 8'(LANE_ID*8 + i);
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    vid.h[i] = 16'(LANE_ID*4 + i);
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    vid.w[i] = 32'(LANE_ID*2 + i);
                end
            end
            default: vid.d = 64'(LANE_ID);
        endcase
    end

    always_comb begin
        case (op_bus.op)
            OP_ADD, OP_SUB, OP_SADDU, OP_SSUBU, OP_MACC: vd_o = add_res;
            OP_MUL:  vd_o = mul_res;
            OP_AND:  vd_o = vs1.d & vs2.d;
            OP_OR:   vd_o = vs1.d | vs2.d;
            OP_XOR:  vd_o = vs1.d ^ vs2.d;
            OP_VID:  vd_o = vid;
            default: vd_o = '0;
        endcase
    end

endmodule

/* source/vec_addsub.sv */
/*
 * Per-element adder and subtractor with wrapping and unsigned
 * saturating modes, sat flag raised on any clamped element
 */
`timescale 1ns/1ps

module vec_addsub
    import vec_pkg::*;
(
    input  vec_op_e    op_i,
    input  sew_e       sew_i,
    input  lane_word_u a_i,
    input  lane_word_u b_i,
    output lane_word_u sum_o,
    output logic       sat_o        // At least one element clamped
);

    logic        sub;
    logic        sat_mode;
    logic [64:0] elem_r;            // Element result, carry at bit SEW
    logic        ovf;

    assign sub      = (op_i == OP_SUB) || (op_i == OP_SSUBU);
    assign sat_mode = (op_i == OP_SADDU) || (op_i == OP_SSUBU);

    // Zero-extended operands, so bit SEW of the result is carry or borrow
    function automatic logic [64:0] add_elem(
        input logic [63:0] a,
        input logic [63:0] b,
        input logic        do_sub
    );
        return do_sub ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, b});
    endfunction

    always_comb begin
        sum_o  = '0;
        sat_o  = 1'b0;
        elem_r = '0;
        ovf    = 1'b0;
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    elem_r     = add_elem(64'(a_i.b[i]), 64'(b_i.b[i]), sub);
                    ovf        = sat_mode && elem_r[8];
                    sum_o.b[i] = ovf ? {8{~sub}} : elem_r[7:0];     // Clamp high or low
                    sat_o      = sat_o | ovf;
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    elem_r     = add_elem(64'(a_i.h[i]), 64'(b_i.h[i]), sub);
                    ovf        = sat_mode && elem_r[16];
                    sum_o.h[i] = ovf ? {16{~sub}} : elem_r[15:0];
                    sat_o      = sat_o | ovf;
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    elem_r     = add_elem(64'(a_i.w[i]), 64'(b_i.w[i]), sub);
                    ovf        = sat_mode && elem_r[32];
                    sum_o.w[i] = ovf ? {32{~sub}} : elem_r[31:0];
                    sat_o      = sat_o | ovf;
                end
            end
            default: begin
                elem_r  = add_elem(a_i.d, b_i.d, sub);
                ovf     = sat_mode && elem_r[64];
                sum_o.d = ovf ? {64{~sub}} : elem_r[63:0];
                sat_o   = ovf;
            end
        endcase
    end

endmodule

/* source/vec_ctrl_fsm.sv */
/*
 * Vector unit controller: four-phase req/ack handshake, instruction
 * capture, timer start and result registering
 */
`timescale 1ns/1ps

module vec_ctrl_fsm
    import vec_pkg::*;
#(
    parameter int NUM_LANES = 2
) (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        req_i,      // Request from requester
    input  vec_op_e                     op_i,
    input  sew_e                        sew_i,
    input  logic [NUM_LANES*LANE_W-1:0] vs1_i,
    input  logic [NUM_LANES*LANE_W-1:0] vs2_i,
    input  logic [NUM_LANES*LANE_W-1:0] old_vd_i,
    vec_op_if.ctrl                      op_bus,     // Captured instruction
    output logic                        load_o,     // Start latency timer
    output lat_t                        lat_o,
    input  logic                        done_i,     // Lane results ready
    input  logic [NUM_LANES*LANE_W-1:0] lane_vd_i,
    input  logic [NUM_LANES-1:0]        lane_sat_i,
    output logic                        ack_o,
    output logic [NUM_LANES*LANE_W-1:0] vd_o,
    output logic                        sat_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_EXEC = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

    logic [1:0] state_q;

    assign load_o = (state_q == ST_IDLE) && req_i;  // Accept at E0
    assign lat_o  = lat_of(op_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            ack_o   <= 1'b0;
            vd_o    <= '0;
            sat_o   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (done_i) begin
                        state_q <= ST_ACK;
                        ack_o   <= 1'b1;
                        vd_o    <= lane_vd_i;
                        sat_o   <= |lane_sat_i;     // Any lane clamped
                    end
                end
                ST_ACK: begin
                    if (!req_i) begin               // Requester released
                        state_q <= ST_IDLE;
                        ack_o   <= 1'b0;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Operands held for the lanes until the next accept
    always_ff @(posedge clk_i) begin
        if (load_o) begin
            op_bus.op     <= op_i;
            op_bus.sew    <= sew_i;
            op_bus.vs1    <= vs1_i;
            op_bus.vs2    <= vs2_i;
            op_bus.old_vd <= old_vd_i;
        end
    end

endmodule

/* source/vec_exec_top.sv */
/*
 * SIMD vector execution unit: controller, latency timer and NUM_LANES
 * 64-bit lanes behind a four-phase req/ack handshake
 */
`timescale 1ns/1ps

module vec_exec_top
    import vec_pkg::*;
#(
    parameter int NUM_LANES = 2
) (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        req_i,
    input  vec_op_e                     op_i,
    input  sew_e                        sew_i,
    input  logic [NUM_LANES*LANE_W-1:0] vs1_i,
    input  logic [NUM_LANES*LANE_W-1:0] vs2_i,
    input  logic [NUM_LANES*LANE_W-1:0] old_vd_i,
    output logic                        ack_o,
    output logic [NUM_LANES*LANE_W-1:0] vd_o,
    output logic                        sat_o
);

    logic                        load;
    lat_t                        lat;
    logic                        done;
    logic [NUM_LANES*LANE_W-1:0] lane_vd;   // All lane results joined
    logic [NUM_LANES-1:0]        lane_sat;  // One sat bit per lane

    vec_op_if #(.NUM_LANES(NUM_LANES)) op_bus ();

    vec_ctrl_fsm #(.NUM_LANES(NUM_LANES)) u_ctrl (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req_i      (req_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .vs1_i      (vs1_i),
        .vs2_i      (vs2_i),
        .old_vd_i   (old_vd_i),
        .op_bus     (op_bus.ctrl),
        .load_o     (load),
        .lat_o      (lat),
        .done_i     (done),
        .lane_vd_i  (lane_vd),
        .lane_sat_i (lane_sat),
        .ack_o      (ack_o),
        .vd_o       (vd_o),
        .sat_o      (sat_o)
    );

    vec_latency_timer u_timer (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .load_i (load),
        .lat_i  (lat),
        .done_o (done)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        functional_unit #(.LANE_ID(g)) u_fu (
            .clk_i  (clk_i),
            .rstn_i (rstn_i),
            .op_bus (op_bus.lane),
            .vd_o   (lane_vd[g*LANE_W +: LANE_W]),
            .sat_o  (lane_sat[g])
        );
    end

endmodule

/* source/vec_latency_timer.sv */
/*
 * Latency timer: counts down an operation's extra cycles, flags done at zero
 */
`timescale 1ns/1ps

module vec_latency_timer
    import vec_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic load_i,        // Start a new wait
    input  lat_t lat_i,         // Cycles to wait after load
    output logic done_o         // Result ready this cycle
);

    lat_t count_q;
    logic active_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            count_q  <= '0;
            active_q <= 1'b0;
        end else if (load_i) begin
            count_q  <= lat_i;
            active_q <= 1'b1;
        end else if (active_q) begin
            if (count_q == '0) begin
                active_q <= 1'b0;                   // Done seen by controller
            end else begin
                count_q <= lat_t'(count_q - 2'd1);
            end
        end
    end

    assign done_o = active_q && (count_q == '0);

endmodule

/* source/vec_mul.sv */
/*
 * Per-element unsigned multiplier, low SEW bits of each product,
 * one register stage on the output
 */
`timescale 1ns/1ps

module vec_mul
    import vec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  sew_e       sew_i,
    input  lane_word_u a_i,
    input  lane_word_u b_i,
    output lane_word_u prod_o       // Valid one edge after inputs
);

    lane_word_u prod_d;

    // Assignment width keeps only the low half of each product
    always_comb begin
        prod_d = '0;
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    prod_d.b[i] = a_i.b[i] * b_i.b[i];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    prod_d.h[i] = a_i.h[i] * b_i.h[i];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    prod_d.w[i] = a_i.w[i] * b_i.w[i];
                end
            end
            default: begin
                prod_d.d = a_i.d * b_i.d;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prod_o <= '0;
        end else begin
            prod_o <= prod_d;
        end
    end

endmodule

/* source/vec_op_if.sv */
/*
 * Captured instruction bus from the controller to the lanes
 */
`timescale 1ns/1ps

interface vec_op_if
    import vec_pkg::*;
#(
    parameter int NUM_LANES = 2
) ();

    vec_op_e                     op;        // Operation
    sew_e                        sew;       // Element width
    logic [NUM_LANES*LANE_W-1:0] vs1;       // Source operand 1
    logic [NUM_LANES*LANE_W-1:0] vs2;       // Source operand 2
    logic [NUM_LANES*LANE_W-1:0] old_vd;    // Accumulator for MACC

    modport ctrl (output op, sew, vs1, vs2, old_vd);
    modport lane (input op, sew, vs1, vs2, old_vd);

endinterface

/* source/vec_pkg.sv */
/*
 * Vector unit package: lane width, operation and SEW codes,
 * latency counts and the multi-view lane word
 */
package vec_pkg;

    localparam int LANE_W = 64;             // Bits per functional unit

    typedef enum logic [3:0] {
        OP_ADD,                             // Wrapping add
        OP_SUB,                             // Wrapping subtract, vs2 - vs1
        OP_SADDU,                           // Unsigned saturating add
        OP_SSUBU,                           // Unsigned saturating subtract
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,                             // Low half of product
        OP_MACC,                            // vs1 * vs2 + old vd
        OP_VID                              // Element index
    } vec_op_e;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    typedef logic [1:0] lat_t;              // Extra cycles before result is ready

    // One lane word seen as elements of each SEW
    typedef union packed {
        logic [7:0][7:0]  b;                // Eight bytes
        logic [3:0][15:0] h;                // Four halves
        logic [1:0][31:0] w;                // Two words
        logic [63:0]      d;                // One doubleword
    } lane_word_u;

    function automatic lat_t lat_of(input vec_op_e op);
        case (op)
            OP_MUL:  return 2'd1;           // Multiplier register
            OP_MACC: return 2'd2;           // Plus register before adder
            default: return 2'd0;
        endcase
    endfunction

endpackage

/* testbench/vec_exec_tb.sv */
/*
 * Testbench for the vector unit: random instructions over the
 * four-phase handshake, checked against the reference model
 */
`timescale 1ns/1ps

module vec_exec_tb
    import vec_pkg::*, vec_ref_pkg::*;
();

    localparam int NUM_LANES = 2;
    localparam int VW        = NUM_LANES * LANE_W;
    localparam int TIMEOUT   = 20;                  // Cycles allowed per wait

    logic          clk_i;
    logic          rstn_i;
    logic          req_i;
    vec_op_e       op_i;
    sew_e          sew_i;
    logic [VW-1:0] vs1_i;
    logic [VW-1:0] vs2_i;
    logic [VW-1:0] old_vd_i;
    logic          ack_o;
    logic [VW-1:0] vd_o;
    logic          sat_o;

    int   seed = 32'h17846ece;
    int   errors = 0;
    int   base_errors = 0;
    int   checks = 0;
    int   tests = 0;
    int   sat_hits = 0;
    logic timed_out = 1'b0;

    vec_exec_top #(.NUM_LANES(NUM_LANES)) UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [VW-1:0] actual,
                               input logic [VW-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("Test %-14s done, %0d errors", name, errors - base_errors);
        base_errors = errors;
    endtask

    task automatic check_reset_outputs();
        check_value("ack_o", VW'(ack_o), '0);
        check_value("vd_o", vd_o, '0);
        check_value("sat_o", VW'(sat_o), '0);
    endtask

    // Steps whole cycles until ack_o reaches level
    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack_o !== level && cycles < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (ack_o !== level) begin
            $display("Timeout: ack_o did not go to %0b within %0d cycles", level, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    function automatic logic [VW-1:0] rand_vec(input logic biased);
        logic [VW-1:0] v;
        logic [31:0]   r;
        for (int i = 0; i < VW / 8; i++) begin
            r = $random(seed);
            v[i*8 +: 8] = biased ? {{4{r[8]}}, r[3:0]} : r[7:0];   // Near all ones or zero
        end
        return v;
    endfunction

    // One instruction through the full handshake, held for hold extra cycles
    task automatic run_op(input vec_op_e op, input sew_e sew, input logic biased, input int hold);
        logic [VW-1:0] exp_vd;
        logic          exp_sat;
        logic          lane_sat;
        int            cycles;
        if (timed_out) return;
        op_i     = op;
        sew_i    = sew;
        vs1_i    = rand_vec(biased);
        vs2_i    = rand_vec(biased);
        old_vd_i = rand_vec(1'b0);
        exp_sat  = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            exp_vd[k*LANE_W +: LANE_W] = model_lane(op, sew, vs1_i[k*LANE_W +: LANE_W],
                vs2_i[k*LANE_W +: LANE_W], old_vd_i[k*LANE_W +: LANE_W], k, lane_sat);
            exp_sat = exp_sat | lane_sat;
        end
        req_i = 1'b1;
        @(posedge clk_i);                           // Edge that accepts the request
        #1;
        wait_ack(1'b1, cycles);
        if (timed_out) return;
        check_value("ack latency", VW'(cycles), VW'(1 + lat_of(op)));
        check_value("vd_o", vd_o, exp_vd);
        check_value("sat_o", VW'(sat_o), VW'(exp_sat));
        sat_hits += exp_sat;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk_i);
            #1;
            check_value("ack_o", VW'(ack_o), VW'(1));
            check_value("vd_o", vd_o, exp_vd);
            check_value("sat_o", VW'(sat_o), VW'(exp_sat));
        end
        req_i = 1'b0;
        wait_ack(1'b0, cycles);
        if (timed_out) return;
        check_value("ack fall latency", VW'(cycles), VW'(1));  // Drops on the next edge
    endtask

    initial begin
        vec_op_e op;
        int      hold;
        rstn_i   = 1'b0;
        req_i    = 1'b0;
        op_i     = OP_ADD;
        sew_i    = SEW_8;
        vs1_i    = '0;
        vs2_i    = '0;
        old_vd_i = '0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk_i);
            #1;
            check_reset_outputs();
        end
        rstn_i = 1'b1;
        @(posedge clk_i);
        #1;
        check_reset_outputs();
        report_test("reset");

        for (int i = 0; i < 200; i++) begin
            op = ($random(seed) & 1) ? OP_SUB : OP_ADD;
            run_op(op, sew_e'(i % 4), 1'b0, 0);
        end
        report_test("wrapping");

        for (int i = 0; i < 100; i++) begin
            op = ($random(seed) & 1) ? OP_SSUBU : OP_SADDU;
            run_op(op, sew_e'(i % 4), 1'b1, 0);
        end
        if (sat_hits == 0) begin
            errors++;
            $display("The saturation test never produced a clamped element");
        end
        report_test("saturation");

        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 5; k++) begin
                run_op(OP_AND, sew_e'(s), 1'b0, 0);
                run_op(OP_OR, sew_e'(s), 1'b0, 0);
                run_op(OP_XOR, sew_e'(s), 1'b0, 0);
            end
            run_op(OP_VID, sew_e'(s), 1'b0, 0);
        end
        report_test("logic and vid");

        for (int i = 0; i < 100; i++) begin
            op = ($random(seed) & 1) ? OP_MACC : OP_MUL;
            run_op(op, sew_e'(i % 4), 1'b0, 0);
        end
        report_test("mul and macc");

        for (int i = 0; i < 50; i++) begin
            op   = vec_op_e'($unsigned($random(seed)) % 10);
            hold = $unsigned($random(seed)) % 11;
            run_op(op, sew_e'(i % 4), 1'b0, hold);
        end
        report_test("back-pressure");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/vec_ref_pkg.sv */
/*
 * Reference model for the vector unit: expected lane result and
 * saturation flag, computed element by element
 */
package vec_ref_pkg;
    import vec_pkg::*;

    function automatic logic [63:0] model_lane(
        input  vec_op_e     op,
        input  sew_e        sew,
        input  logic [63:0] vs1,
        input  logic [63:0] vs2,
        input  logic [63:0] old_vd,
        input  int          lane,
        output logic        sat
    );
        int           bits;
        int           n;
        logic [127:0] mask;
        logic [127:0] x;
        logic [127:0] y;
        logic [127:0] r;
        logic [63:0]  res;
        bits = 8 << sew;
        n    = 64 / bits;
        mask = (128'd1 << bits) - 1;
        res  = '0;
        sat  = 1'b0;
        for (int i = 0; i < n; i++) begin
            x = (vs1 >> (i * bits)) & mask;
            y = (vs2 >> (i * bits)) & mask;
            case (op)
                OP_ADD:   r = y + x;
                OP_SUB:   r = y - x;                   // vs2 minus vs1
                OP_SADDU: r = (y + x > mask) ? mask : y + x;
                OP_SSUBU: r = (y < x) ? 128'd0 : y - x;
                OP_MUL:   r = x * y;
                OP_MACC:  r = ((x * y) & mask) + ((old_vd >> (i * bits)) & mask);
                OP_VID:   r = lane * n + i;            // Index across all lanes
                OP_AND:   r = x & y;
                OP_OR:    r = x | y;
                OP_XOR:   r = x ^ y;
                default:  r = '0;
            endcase
            if ((op == OP_SADDU && y + x > mask) || (op == OP_SSUBU && y < x)) begin
                sat = 1'b1;
            end
            res = res | 64'((r & mask) << (i * bits));
        end
        return res;
    endfunction

endpackage

/* vec_exec.f */
source/vec_pkg.sv
source/vec_op_if.sv
source/vec_ctrl_fsm.sv
source/vec_latency_timer.sv
source/vec_addsub.sv
source/vec_mul.sv
source/functional_unit.sv
source/vec_exec_top.sv
testbench/vec_ref_pkg.sv
testbench/vec_exec_tb.sv
